// File: tb.f
+incdir+logic
logic/riffaPkg.sv
logic/hostRegs.sv
logic/chnlReqEngine.sv
logic/reqArbiter.sv
logic/creditFlowCtrl.sv
logic/intrCtrl.sv
logic/riffaCore.sv
test/riffaCore_properties.sv
test/tb.sv

// File: Bender.yml
package:
  name: riffa_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/riffaPkg.sv
      - logic/hostRegs.sv
      - logic/chnlReqEngine.sv
      - logic/reqArbiter.sv
      - logic/creditFlowCtrl.sv
      - logic/intrCtrl.sv
      - logic/riffaCore.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - test/riffaCore_properties.sv
      - test/tb.sv

// File: test/tb.sv
`timescale 1ns/1ns
`include "riffa_settings.svh"

module tb;
    localparam int NumChnl = `RIFFA_NUM_CHNL;
    localparam int Timeout = 200;

    logic               CLK = 1'b0;
    logic               arstN = 1'b0;
    logic               rstIn = 1'b0;
    logic               rstOut;
    logic               wrReq = 1'b0;
    riffaPkg::regAddrT  wrAddr = '0;
    riffaPkg::regDataT  wrData = '0;
    logic               rdReq = 1'b0;
    riffaPkg::regAddrT  rdAddr = '0;
    logic               rdValid;
    riffaPkg::regDataT  rdData;
    logic               busMasterEnable = 1'b0;
    logic [5:0]         linkWidth = '0;
    logic [2:0]         maxReadReq = '0;
    logic [2:0]         maxPayload = '0;
    riffaPkg::creditT   maxOutstanding = 4'd4;
    logic               reqValid;
    logic               reqReady = 1'b1;
    riffaPkg::addrT     reqAddr;
    riffaPkg::lenT      reqLen;
    riffaPkg::tagT      reqTag;
    logic               cplDone = 1'b0;
    riffaPkg::tagT      cplTag = '0;
    logic               msiEnable = 1'b0;
    logic               msiRdy = 1'b0;
    logic               msiRequest;

    logic [31:0]        lfsr = 32'd96724;
    string              testName = "reset";
    int                 mismatches = 0;
    int                 otherErrors = 0;
    int                 xferCount = 0;
    int                 outstanding = 0;
    logic               stallOn = 1'b0;
    logic               prevRdReq = 1'b0;
    riffaPkg::chnlMaskT doneMask = '0;
    riffaPkg::tagT      lastTag = '0;
    riffaPkg::addrT     expAddr [NumChnl];
    riffaPkg::lenT      expLen [NumChnl];
    riffaPkg::regDataT  expRd [$];
    riffaPkg::tagT      expTags [$];

    always #20 CLK = ~CLK;

    riffaCore u_dut (.*);

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return r;
    endfunction

    function automatic riffaPkg::regDataT refSettings(input logic bme, input logic [5:0] lw,
                                                      input logic [2:0] mrr,
                                                      input logic [2:0] mp);
        riffaPkg::regDataT w;
        w = '0;
        w[3:0] = `RIFFA_NUM_CHNL;
        w[4] = bme;
        w[10:5] = lw;
        w[13:11] = mrr;
        w[16:14] = mp;
        w[20:17] = `RIFFA_DATA_W_CODE;
        return w;
    endfunction

    // Length register keeps only the low bits of the word
    function automatic riffaPkg::lenT refLen(input riffaPkg::regDataT w);
        return w[`RIFFA_LEN_W-1:0];
    endfunction

    // Next pending channel above the last winner or else the lowest one
    function automatic riffaPkg::tagT rrNext(input riffaPkg::tagT last,
                                             input riffaPkg::chnlMaskT pend);
        int above;
        int lowest;
        above = -1;
        lowest = -1;
        for (int i = NumChnl - 1; i >= 0; i--) begin
            if (pend[i]) begin
                lowest = i;
                if (i > int'(last)) above = i;
            end
        end
        if (above >= 0) return riffaPkg::tagT'(above);
        if (lowest >= 0) return riffaPkg::tagT'(lowest);
        return last;
    endfunction

    task automatic checkReg(input string name, input riffaPkg::regDataT exp,
                            input riffaPkg::regDataT act);
        if (act !== exp) begin
            mismatches++;
            $display("FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    task automatic checkAddr(input string name, input riffaPkg::addrT exp,
                             input riffaPkg::addrT act);
        if (act !== exp) begin
            mismatches++;
            $display("FAILED %s address: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    task automatic checkLen(input string name, input riffaPkg::lenT exp,
                            input riffaPkg::lenT act);
        if (act !== exp) begin
            mismatches++;
            $display("FAILED %s length: expected 0x%h, actual 0x%h", name, exp, act);
        end
    endtask

    task automatic checkTag(input string name, input riffaPkg::tagT exp,
                            input riffaPkg::tagT act);
        if (act !== exp) begin
            mismatches++;
            $display("FAILED %s tag: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkCycles(input string name, input int exp, input int act);
        if (act != exp) begin
            mismatches++;
            $display("FAILED %s rstOut cycles: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic reportError(input string what);
        otherErrors++;
        $display("ERROR in %s: %s", testName, what);
    endtask

    task automatic endRun();
        int propFails;
        propFails = u_dut.u_props.failCount;
        $display("Checks done: %0d value mismatches, %0d other errors, %0d assertion failures",
                 mismatches, otherErrors, propFails);
        if (mismatches + otherErrors + propFails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // Transfers, completions and read responses
    always @(posedge CLK) begin
        riffaPkg::tagT t;
        if (arstN) begin
            if (rdValid !== prevRdReq) reportError("read response not one cycle after the request");
            if (rdValid) begin
                if (expRd.size() == 0) begin
                    reportError("read response without a read");
                end else begin
                    checkReg(testName, expRd.pop_front(), rdData);
                end
            end
            if (cplDone) outstanding--;
            if (reqValid && reqReady) begin
                if (expTags.size() == 0) begin
                    reportError("unexpected request transfer");
                end else begin
                    t = expTags.pop_front();
                    checkTag(testName, t, reqTag);
                    checkAddr(testName, expAddr[t], reqAddr);
                    checkLen(testName, expLen[t], reqLen);
                end
                xferCount++;
                outstanding++;
            end
            if (outstanding > int'(maxOutstanding)) reportError("credit limit exceeded");
        end
        prevRdReq = rdReq;
    end

    task automatic nextCycle();
        @(negedge CLK);
        if (stallOn) begin
            // Ready about three cycles in four
            reqReady = (randBits(2) != 0);
        end
    endtask

    task automatic writeReg(input riffaPkg::regAddrT a, input riffaPkg::regDataT d);
        wrReq = 1'b1;
        wrAddr = a;
        wrData = d;
        nextCycle();
        wrReq = 1'b0;
    endtask

    task automatic readReg(input riffaPkg::regAddrT a, input riffaPkg::regDataT exp);
        expRd.push_back(exp);
        rdReq = 1'b1;
        rdAddr = a;
        nextCycle();
        rdReq = 1'b0;
    endtask

    task automatic loadChannel(input int c);
        riffaPkg::regDataT a;
        riffaPkg::regDataT l;
        a = randBits(32);
        l = randBits(16);
        expAddr[c] = a;
        expLen[c] = refLen(l);
        writeReg(riffaPkg::regAddrT'(`RIFFA_REG_CHNL_BASE + 2 * c), a);
        writeReg(riffaPkg::regAddrT'(`RIFFA_REG_CHNL_BASE + 2 * c + 1), l);
    endtask

    task automatic complete(input int c);
        cplDone = 1'b1;
        cplTag = riffaPkg::tagT'(c);
        doneMask[c] = 1'b1;
        nextCycle();
        cplDone = 1'b0;
    endtask

    function automatic logic probe(input string sig);
        case (sig)
            "rstOut": return rstOut;
            "msiRequest": return msiRequest;
            default: return reqValid;
        endcase
    endfunction

    task automatic waitLevel(input string sig, input logic level);
        int n;
        n = 0;
        while (probe(sig) !== level) begin
            nextCycle();
            n++;
            if (n > Timeout) begin
                reportError($sformatf("timeout waiting for %s to become %0b", sig, level));
                endRun();
            end
        end
    endtask

    task automatic waitXfers(input int target);
        int n;
        n = 0;
        while (xferCount < target) begin
            nextCycle();
            n++;
            if (n > Timeout) begin
                reportError("timeout waiting for a request transfer");
                endRun();
            end
        end
    endtask

    task automatic measureRstOut(input int exp);
        int n;
        n = 0;
        while (rstOut === 1'b1 && n <= Timeout) begin
            n++;
            nextCycle();
        end
        checkCycles(testName, exp, n);
    endtask

    initial begin
        int base;
        int c;
        riffaPkg::tagT first;
        riffaPkg::chnlMaskT rest;
        repeat (2) nextCycle();
        arstN = 1'b1;
        if (reqValid !== 1'b0 || rdValid !== 1'b0 || msiRequest !== 1'b0) begin
            reportError("outputs not idle after reset");
        end
        measureRstOut(`RIFFA_RST_STRETCH);

        testName = "settings read";
        busMasterEnable = 1'(randBits(1));
        linkWidth = 6'(randBits(6));
        maxReadReq = 3'(randBits(3));
        maxPayload = 3'(randBits(3));
        nextCycle();
        readReg(`RIFFA_REG_SETTINGS,
                refSettings(busMasterEnable, linkWidth, maxReadReq, maxPayload));
        measureRstOut(`RIFFA_RST_STRETCH);

        testName = "single request";
        expTags.push_back(0);
        loadChannel(0);
        waitXfers(xferCount + 1);
        complete(0);
        lastTag = 0;

        // Credits held at zero so both channels pend together
        testName = "arbitration";
        stallOn = 1'b1;
        for (int round = 0; round < 2; round++) begin
            maxOutstanding = '0;
            base = xferCount;
            loadChannel(0);
            loadChannel(1);
            nextCycle();
            nextCycle();
            first = rrNext(lastTag, '1);
            rest = '1;
            rest[first] = 1'b0;
            expTags.push_back(first);
            expTags.push_back(rrNext(first, rest));
            lastTag = expTags[1];
            maxOutstanding = 4'd2;
            waitXfers(base + 2);
            c = int'(randBits(1));
            complete(c);
            complete(NumChnl - 1 - c);
        end
        stallOn = 1'b0;
        reqReady = 1'b1;

        testName = "credit limit";
        maxOutstanding = 4'd1;
        base = xferCount;
        expTags.push_back(0);
        expTags.push_back(1);
        loadChannel(0);
        loadChannel(1);
        waitXfers(base + 1);
        repeat (6) nextCycle();
        if (xferCount != base + 1) reportError("second request issued before the completion");
        complete(0);
        waitXfers(base + 2);
        complete(1);
        maxOutstanding = 4'd4;

        testName = "interrupts";
        if (msiRequest !== 1'b0) reportError("MSI request raised while MSI is disabled");
        readReg(`RIFFA_REG_VECTOR, riffaPkg::regDataT'(doneMask));
        doneMask = '0;
        msiEnable = 1'b1;
        c = int'(randBits(1));
        expTags.push_back(riffaPkg::tagT'(c));
        loadChannel(c);
        waitXfers(xferCount + 1);
        complete(c);
        waitLevel("msiRequest", 1'b1);
        msiRdy = 1'b1;
        nextCycle();
        msiRdy = 1'b0;
        waitLevel("msiRequest", 1'b0);
        readReg(`RIFFA_REG_VECTOR, riffaPkg::regDataT'(doneMask));
        readReg(`RIFFA_REG_VECTOR, '0);
        doneMask = '0;

        // Request parked on the stalled bus when rstIn fires
        testName = "soft reset";
        reqReady = 1'b0;
        loadChannel(0);
        waitLevel("reqValid", 1'b1);
        rstIn = 1'b1;
        nextCycle();
        rstIn = 1'b0;
        waitLevel("rstOut", 1'b1);
        waitLevel("rstOut", 1'b0);
        reqReady = 1'b1;
        base = xferCount;
        repeat (8) nextCycle();
        if (xferCount != base) reportError("transfer after soft reset without a length write");
        expTags.push_back(0);
        loadChannel(0);
        waitXfers(base + 1);
        complete(0);
        repeat (4) nextCycle();
        endRun();
    end

    initial begin
        #(40 * 5000);
        reportError("simulation watchdog expired");
        endRun();
    end

endmodule

// File: test/riffaCore_properties.sv
`timescale 1ns/1ns

module riffaCoreProps (
    input logic           CLK,
    input logic           arstN,
    input logic           rstOut,
    input logic           rdReq,
    input logic           rdValid,
    input logic           reqValid,
    input logic           reqReady,
    input riffaPkg::addrT reqAddr,
    input riffaPkg::lenT  reqLen,
    input riffaPkg::tagT  reqTag,
    input logic           msiRequest
);
    int failCount = 0;

    // Stalled request holds until the bus takes it
    reqHold: assert property (@(posedge CLK) disable iff (!arstN)
        reqValid && !reqReady && !rstOut |=>
            reqValid && $stable(reqAddr) && $stable(reqLen) && $stable(reqTag))
        else begin
            failCount++;
            $error("request changed under back-pressure");
        end

    rdAnswer: assert property (@(posedge CLK) disable iff (!arstN) rdReq |=> rdValid)
        else begin
            failCount++;
            $error("no read response one cycle after the request");
        end

    rdQuiet: assert property (@(posedge CLK) disable iff (!arstN) !rdReq |=> !rdValid)
        else begin
            failCount++;
            $error("read response without a request");
        end

    // Clear takes one edge to reach the registers
    rstQuiet: assert property (@(posedge CLK) disable iff (!arstN)
        rstOut |=> !reqValid && !msiRequest)
        else begin
            failCount++;
            $error("request or MSI active during soft reset");
        end

endmodule

bind riffaCore riffaCoreProps u_props (
    .CLK(CLK), .arstN(arstN), .rstOut(rstOut), .rdReq(rdReq), .rdValid(rdValid),
    .reqValid(reqValid), .reqReady(reqReady), .reqAddr(reqAddr), .reqLen(reqLen),
    .reqTag(reqTag), .msiRequest(msiRequest)
);

// File: logic/riffaCore.sv
`timescale 1ns/1ns
`include "riffa_settings.svh"

module riffaCore (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              rstIn,
    output logic              rstOut,
    input  logic              wrReq,
    input  riffaPkg::regAddrT wrAddr,
    input  riffaPkg::regDataT wrData,
    input  logic              rdReq,
    input  riffaPkg::regAddrT rdAddr,
    output logic              rdValid,
    output riffaPkg::regDataT rdData,
    input  logic              busMasterEnable,
    input  logic [5:0]        linkWidth,
    input  logic [2:0]        maxReadReq,
    input  logic [2:0]        maxPayload,
    input  riffaPkg::creditT  maxOutstanding,
    output logic              reqValid,
    input  logic              reqReady,
    output riffaPkg::addrT    reqAddr,
    output riffaPkg::lenT     reqLen,
    output riffaPkg::tagT     reqTag,
    input  logic              cplDone,
    input  riffaPkg::tagT     cplTag,
    input  logic              msiEnable,
    input  logic              msiRdy,
    output logic              msiRequest
);
    riffaPkg::regDataT  chnlData;
    riffaPkg::chnlMaskT addrWr;
    riffaPkg::chnlMaskT lenWr;
    riffaPkg::chnlMaskT reqPend;
    riffaPkg::chnlMaskT grant;
    riffaPkg::chnlMaskT chnlDone;
    riffaPkg::chnlMaskT vector;
    riffaPkg::addrT     chnlAddr [`RIFFA_NUM_CHNL];
    riffaPkg::lenT      chnlLen [`RIFFA_NUM_CHNL];
    logic               vectorRd;
    logic               softRst;
    logic               reqFire;
    logic               spaceAvail;

    assign rstOut = softRst;

    hostRegs u_hostRegs (
        .CLK(CLK), .arstN(arstN), .rstIn(rstIn),
        .wrReq(wrReq), .wrAddr(wrAddr), .wrData(wrData),
        .rdReq(rdReq), .rdAddr(rdAddr),
        .busMasterEnable(busMasterEnable), .linkWidth(linkWidth),
        .maxReadReq(maxReadReq), .maxPayload(maxPayload), .vector(vector),
        .rdValid(rdValid), .rdData(rdData), .chnlData(chnlData),
        .addrWr(addrWr), .lenWr(lenWr), .vectorRd(vectorRd), .softRst(softRst)
    );

    // Channels share the request bus as peers
    for (genvar c = 0; c < `RIFFA_NUM_CHNL; c++) begin : g_chnl
        chnlReqEngine #(.chnlIdx(c)) u_chnl (
            .CLK(CLK), .arstN(arstN), .softRst(softRst), .chnlData(chnlData),
            .addrWr(addrWr[c]), .lenWr(lenWr[c]), .grant(grant[c]),
            .cplDone(cplDone), .cplTag(cplTag), .reqPend(reqPend[c]),
            .reqAddr(chnlAddr[c]), .reqLen(chnlLen[c]), .done(chnlDone[c])
        );
    end

    reqArbiter u_reqArbiter (
        .CLK(CLK), .arstN(arstN), .softRst(softRst), .reqPend(reqPend),
        .chnlAddr(chnlAddr), .chnlLen(chnlLen), .spaceAvail(spaceAvail),
        .reqReady(reqReady), .grant(grant), .reqFire(reqFire), .reqValid(reqValid),
        .reqAddr(reqAddr), .reqLen(reqLen), .reqTag(reqTag)
    );

    creditFlowCtrl u_creditFlowCtrl (
        .CLK(CLK), .arstN(arstN), .softRst(softRst), .maxOutstanding(maxOutstanding),
        .reqFire(reqFire), .cplDone(cplDone), .spaceAvail(spaceAvail)
    );

    intrCtrl u_intrCtrl (
        .CLK(CLK), .arstN(arstN), .softRst(softRst), .chnlDone(chnlDone),
        .vectorRd(vectorRd), .msiEnable(msiEnable), .msiRdy(msiRdy),
        .vector(vector), .msiRequest(msiRequest)
    );

endmodule

// File: logic/intrCtrl.sv
`timescale 1ns/1ns

module intrCtrl (
    input  logic               CLK,
    input  logic               arstN,
    input  logic               softRst,
    input  riffaPkg::chnlMaskT chnlDone,
    input  logic               vectorRd,
    input  logic               msiEnable,
    input  logic               msiRdy,
    output riffaPkg::chnlMaskT vector,
    output logic               msiRequest
);
    logic msiSent;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            vector <= '0;
        end else if (softRst) begin
            vector <= '0;
        end else if (vectorRd) begin
            // New done pulses survive the clear
            vector <= chnlDone;
        end else begin
            vector <= vector | chnlDone;
        end
    end

    // One MSI per nonzero period of the vector
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            msiRequest <= 1'b0;
            msiSent <= 1'b0;
        end else if (softRst) begin
            msiRequest <= 1'b0;
            msiSent <= 1'b0;
        end else if (msiRequest) begin
            if (msiRdy) begin
                msiRequest <= 1'b0;
                msiSent <= 1'b1;
            end
        end else if (msiSent) begin
            if (vector == '0) msiSent <= 1'b0;
        end else if ((vector != '0) && msiEnable) begin
            msiRequest <= 1'b1;
        end
    end

endmodule

// File: logic/creditFlowCtrl.sv
`timescale 1ns/1ns

module creditFlowCtrl (
    input  logic             CLK,
    input  logic             arstN,
    input  logic             softRst,
    input  riffaPkg::creditT maxOutstanding,
    input  logic             reqFire,
    input  logic             cplDone,
    output logic             spaceAvail
);
    riffaPkg::creditT count;
    logic             cplTake;

    // Stray completions never drive the count below zero
    assign cplTake = cplDone && (count != '0);

    // Count includes the request parked in the arbiter
    assign spaceAvail = (count < maxOutstanding);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (softRst) begin
            count <= '0;
        end else if (reqFire && !cplTake) begin
            count <= count + 1'b1;
        end else if (!reqFire && cplTake) begin
            count <= count - 1'b1;
        end
    end

endmodule

// File: logic/reqArbiter.sv
`timescale 1ns/1ns
`include "riffa_settings.svh"

module reqArbiter (
    input  logic               CLK,
    input  logic               arstN,
    input  logic               softRst,
    input  riffaPkg::chnlMaskT reqPend,
    input  riffaPkg::addrT     chnlAddr [`RIFFA_NUM_CHNL],
    input  riffaPkg::lenT      chnlLen [`RIFFA_NUM_CHNL],
    input  logic               spaceAvail,
    input  logic               reqReady,
    output riffaPkg::chnlMaskT grant,
    output logic               reqFire,
    output logic               reqValid,
    output riffaPkg::addrT     reqAddr,
    output riffaPkg::lenT      reqLen,
    output riffaPkg::tagT      reqTag
);
    localparam int NumChnl = `RIFFA_NUM_CHNL;

    riffaPkg::tagT lastWin;
    riffaPkg::tagT winner;
    logic          found;
    logic          load;

    // Search starts one past the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        winner = lastWin;
        for (int k = 1; k <= NumChnl; k++) begin
            idx = (int'(lastWin) + k) % NumChnl;
            if (!found && reqPend[idx]) begin
                found = 1'b1;
                winner = riffaPkg::tagT'(idx);
            end
        end
    end

    // Output slot is free when empty or draining this cycle
    assign load = found && spaceAvail && (!reqValid || reqReady);
    assign reqFire = load;

    always_comb begin
        grant = '0;
        if (load) begin
            grant[winner] = 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            reqValid <= 1'b0;
            lastWin <= riffaPkg::tagT'(NumChnl - 1);
        end else if (softRst) begin
            reqValid <= 1'b0;
            lastWin <= riffaPkg::tagT'(NumChnl - 1);
        end else if (load) begin
            reqValid <= 1'b1;
            lastWin <= winner;
        end else if (reqReady) begin
            reqValid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            reqAddr <= chnlAddr[winner];
            reqLen <= chnlLen[winner];
            reqTag <= winner;
        end
    end

endmodule

// File: logic/chnlReqEngine.sv
`timescale 1ns/1ns

module chnlReqEngine #(
    parameter int chnlIdx = 0
) (
    input  logic              CLK,
    input  logic              arstN,
    input  logic              softRst,
    input  riffaPkg::regDataT chnlData,
    input  logic              addrWr,
    input  logic              lenWr,
    input  logic              grant,
    input  logic              cplDone,
    input  riffaPkg::tagT     cplTag,
    output logic              reqPend,
    output riffaPkg::addrT    reqAddr,
    output riffaPkg::lenT     reqLen,
    output logic              done
);
    riffaPkg::chnlStateT state;
    logic                cplHit;

    assign cplHit = cplDone && (cplTag == riffaPkg::tagT'(chnlIdx));
    assign reqPend = (state == riffaPkg::PEND);
    // Only a completion for an issued request counts
    assign done = (state == riffaPkg::WAIT) && cplHit;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= riffaPkg::IDLE;
        end else if (softRst) begin
            state <= riffaPkg::IDLE;
        end else begin
            case (state)
                riffaPkg::IDLE: if (lenWr) state <= riffaPkg::PEND;
                riffaPkg::PEND: if (grant) state <= riffaPkg::WAIT;
                riffaPkg::WAIT: if (cplHit) state <= riffaPkg::IDLE;
                default: state <= riffaPkg::IDLE;
            endcase
        end
    end

    // Length is locked once the request is accepted
    always_ff @(posedge CLK) begin
        if (addrWr) begin
            reqAddr <= riffaPkg::addrT'(chnlData);
        end
        if (lenWr && (state == riffaPkg::IDLE)) begin
            reqLen <= riffaPkg::lenT'(chnlData);
        end
    end

endmodule

// File: logic/hostRegs.sv
`timescale 1ns/1ns
`include "riffa_settings.svh"

module hostRegs (
    input  logic               CLK,
    input  logic               arstN,
    input  logic               rstIn,
    input  logic               wrReq,
    input  riffaPkg::regAddrT  wrAddr,
    input  riffaPkg::regDataT  wrData,
    input  logic               rdReq,
    input  riffaPkg::regAddrT  rdAddr,
    input  logic               busMasterEnable,
    input  logic [5:0]         linkWidth,
    input  logic [2:0]         maxReadReq,
    input  logic [2:0]         maxPayload,
    input  riffaPkg::chnlMaskT vector,
    output logic               rdValid,
    output riffaPkg::regDataT  rdData,
    output riffaPkg::regDataT  chnlData,
    output riffaPkg::chnlMaskT addrWr,
    output riffaPkg::chnlMaskT lenWr,
    output logic               vectorRd,
    output logic               softRst
);
    localparam int NumChnl = `RIFFA_NUM_CHNL;

    logic [`RIFFA_RST_STRETCH-1:0] stretch;
    logic                          settingsRd;
    riffaPkg::regDataT             settingsWord;
    riffaPkg::chnlMaskT            addrHit;
    riffaPkg::chnlMaskT            lenHit;

    assign settingsWord = {11'd0, 4'(`RIFFA_DATA_W_CODE), maxPayload, maxReadReq,
                           linkWidth, busMasterEnable, 4'(`RIFFA_NUM_CHNL)};

    assign settingsRd = rdReq && (rdAddr == `RIFFA_REG_SETTINGS);
    // Vector clears on the same edge that samples it for rdData
    assign vectorRd = rdReq && (rdAddr == `RIFFA_REG_VECTOR);

    // Two registers per channel, address first
    always_comb begin
        for (int c = 0; c < NumChnl; c++) begin
            addrHit[c] = wrReq && (wrAddr == riffaPkg::regAddrT'(`RIFFA_REG_CHNL_BASE + 2 * c));
            lenHit[c] = wrReq && (wrAddr == riffaPkg::regAddrT'(`RIFFA_REG_CHNL_BASE + 2 * c + 1));
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            addrWr <= '0;
            lenWr <= '0;
            rdValid <= 1'b0;
            stretch <= '1;
        end else begin
            addrWr <= addrHit;
            lenWr <= lenHit;
            rdValid <= rdReq;
            // Any trigger restarts the full stretch
            if (rstIn || settingsRd) begin
                stretch <= '1;
            end else begin
                stretch <= stretch << 1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        chnlData <= wrData;
        if (rdReq) begin
            case (rdAddr)
                `RIFFA_REG_SETTINGS: rdData <= settingsWord;
                `RIFFA_REG_VECTOR: rdData <= riffaPkg::regDataT'(vector);
                default: rdData <= '0;
            endcase
        end
    end

    assign softRst = stretch[`RIFFA_RST_STRETCH-1];

endmodule

// File: logic/riffaPkg.sv
`include "riffa_settings.svh"

package riffaPkg;

    // Tag carries the channel number, never narrower than one bit
    localparam int TagW = (`RIFFA_NUM_CHNL > 1) ? $clog2(`RIFFA_NUM_CHNL) : 1;

    typedef logic [`RIFFA_ADDR_W-1:0] addrT;
    typedef logic [`RIFFA_LEN_W-1:0] lenT;

    typedef logic [`RIFFA_REG_ADDR_W-1:0] regAddrT;
    typedef logic [`RIFFA_REG_DATA_W-1:0] regDataT;

    typedef logic [TagW-1:0] tagT;
    typedef logic [`RIFFA_NUM_CHNL-1:0] chnlMaskT;

    typedef logic [`RIFFA_CREDIT_W-1:0] creditT;

    // Channel read-request engine
    typedef enum logic [1:0] {
        IDLE,
        PEND,
        WAIT
    } chnlStateT;

endpackage

// File: logic/riffa_settings.svh
`ifndef RIFFA_SETTINGS_SVH
`define RIFFA_SETTINGS_SVH

// Core dimensions
`define RIFFA_NUM_CHNL 2
`define RIFFA_ADDR_W 32
`define RIFFA_LEN_W 10
`define RIFFA_REG_ADDR_W 8
`define RIFFA_REG_DATA_W 32

// Max outstanding read requests
`define RIFFA_CREDIT_W 4

// Reported in the settings word
`define RIFFA_DATA_W_CODE 4

// Cycles rstOut stays high after a trigger
`define RIFFA_RST_STRETCH 5

// Register map
`define RIFFA_REG_SETTINGS 8'h00
`define RIFFA_REG_VECTOR 8'h01
`define RIFFA_REG_CHNL_BASE 8'h10

`endif
